//--- lcStatePkg.sv
/* Life-cycle encodings shared by the fuse controller and its lock logic.
   Provides the codewords, the ordered decoded phase and the decoder. */
`default_nettype none

package lcStatePkg;

  // Width of the encoded life-cycle word as it arrives from outside
  parameter int LcStateWidth = 16;

  // Sparse codewords, one per defined life-cycle state
  // Raw is the unprogrammed value of the life-cycle fuses
  typedef enum logic [LcStateWidth-1:0] {
    LcRaw           = 16'h0000,
    LcTestUnlocked0 = 16'h3A5C,
    LcTestLocked0   = 16'h71E2,
    LcTestUnlocked1 = 16'hB4C9,
    LcTestLocked1   = 16'hC61F,
    LcTestUnlocked2 = 16'h5E93,
    LcTestLocked2   = 16'h8D27,
    LcTestUnlocked3 = 16'hE3B6,
    LcDev           = 16'h2F4D,
    LcProd          = 16'h96E8,
    LcProdEnd       = 16'h4BD1,
    LcRma           = 16'hF87A
  } lcStateCode;

  // Decoded state in life-cycle order, so a plain compare tells
  // whether one phase comes after another
  typedef enum logic [3:0] {
    DecRaw,
    DecTestUnlocked0,
    DecTestLocked0,
    DecTestUnlocked1,
    DecTestLocked1,
    DecTestUnlocked2,
    DecTestLocked2,
    DecTestUnlocked3,
    DecDev,
    DecProd,
    DecProdEnd,
    DecRma,
    DecScrap
  } decLcState;

  // Maps a codeword to its phase; anything outside the table is Scrap
  function automatic decLcState decodeLcState(input logic [LcStateWidth-1:0] code);
    case (code)
      LcRaw:           return DecRaw;
      LcTestUnlocked0: return DecTestUnlocked0;
      LcTestLocked0:   return DecTestLocked0;
      LcTestUnlocked1: return DecTestUnlocked1;
      LcTestLocked1:   return DecTestLocked1;
      LcTestUnlocked2: return DecTestUnlocked2;
      LcTestLocked2:   return DecTestLocked2;
      LcTestUnlocked3: return DecTestUnlocked3;
      LcDev:           return DecDev;
      LcProd:          return DecProd;
      LcProdEnd:       return DecProdEnd;
      LcRma:           return DecRma;
      default:         return DecScrap;
    endcase
  endfunction

endpackage

`default_nettype wire

//--- otpPartPkg.sv
/* Fuse partition layout: partition count, index type, data width and
   the last life-cycle phase in which each partition accepts writes. */
`default_nettype none

package otpPartPkg;

  import lcStatePkg::*;

  // Partitions 0 to 2 are vendor test, manufacturing and owner
  // Partition 3 holds the life-cycle fuses themselves
  parameter int NumPart = 4;

  // Index of the life-cycle partition, which follows its own lock rule
  parameter int LcPartIdx = NumPart - 1;

  typedef logic [$clog2(NumPart)-1:0] partIdx;

  // Width of one fuse word
  parameter int FuseWidth = 32;

  // Last phase in which each partition may still be programmed
  // Once the decoded state moves past the entry the partition locks
  // The last entry is not used since the life-cycle partition only locks in Scrap
  parameter decLcState PartLcPhase [NumPart] = '{
    DecTestUnlocked3,
    DecDev,
    DecProd,
    DecScrap
  };

endpackage

`default_nettype wire

//--- otpReqIf.sv
/* Captured fuse request passed from the bus decode stage to the fuse array.
   Decode drives every signal, execute only samples them. */
`timescale 1ns/100ps
`default_nettype none

interface otpReqIf
  import otpPartPkg::*;
#(
  parameter int NumPartWords = 8
) ();

  // One-cycle pulse marking a new request
  logic                            valid;
  logic                            write;
  partIdx                          part;
  // Word offset inside the selected partition
  logic [$clog2(NumPartWords)-1:0] word;
  logic [FuseWidth-1:0]            wdata;

  modport decode (output valid, write, part, word, wdata);

  modport execute (input valid, write, part, word, wdata);

endinterface

`default_nettype wire

//--- otpBusDecode.sv
/* Wishbone classic request capture. Takes one bus cycle per transaction and
   hands partition, word, direction and data to the fuse array as a pulse. */
`timescale 1ns/100ps
`default_nettype none

module otpBusDecode
  import otpPartPkg::*;
#(
  parameter int NumPartWords = 8,
  localparam int WordW = $clog2(NumPartWords),
  localparam int AdrW = $bits(partIdx) + WordW
) (
  input  wire logic                 coreClk,
  input  wire logic                 rst,
  input  wire logic                 wbCyc,
  input  wire logic                 wbStb,
  input  wire logic                 wbWe,
  input  wire logic [AdrW-1:0]      wbAdr,
  input  wire logic [FuseWidth-1:0] wbDatW,
  input  wire logic                 rspDone,
  otpReqIf.decode                   req
);

  // Set while a transaction is anywhere in the pipeline
  logic busy;
  logic accept;

  // A held strobe is only taken again once the previous response is out
  assign accept = wbCyc && wbStb && !busy;

  always_ff @(posedge coreClk) begin
    if (rst) begin
      busy      <= 1'b0;
      req.valid <= 1'b0;
    end else begin
      req.valid <= accept;
      if (accept) begin
        busy <= 1'b1;
      end else if (rspDone) begin
        // Clears on the edge after ack or err, so the master has had one
        // edge to drop stb or present its next request
        busy <= 1'b0;
      end
    end
  end

  // Request payload, captured together with the valid pulse
  always_ff @(posedge coreClk) begin
    if (accept) begin
      req.write <= wbWe;
      // Top address bits pick the partition, low bits the word in it
      req.part  <= wbAdr[AdrW-1:WordW];
      req.word  <= wbAdr[WordW-1:0];
      req.wdata <= wbDatW;
    end
  end

endmodule

`default_nettype wire

//--- lcPartitionLock.sv
/* Life-cycle driven write lock. Decodes and registers the life-cycle word
   and locks every partition whose programming phase has passed. */
`timescale 1ns/100ps
`default_nettype none

module lcPartitionLock
  import lcStatePkg::*;
  import otpPartPkg::*;
(
  input  wire logic                    coreClk,
  input  wire logic                    rst,
  input  wire logic [LcStateWidth-1:0] lcState,
  output logic      [NumPart-1:0]      partWriteLock
);

  decLcState decState;

  // Registering here gives the one-cycle delay from lcState to the lock
  always_ff @(posedge coreClk) begin
    if (rst) begin
      decState <= DecRaw;
    end else begin
      decState <= decodeLcState(lcState);
    end
  end

  // The phase order of decLcState makes the lock a simple compare
  always_comb begin
    for (int i = 0; i < NumPart; i++) begin
      if (i == LcPartIdx) begin
        // Life-cycle fuses stay writable until the device is scrapped
        partWriteLock[i] = (decState == DecScrap);
      end else begin
        partWriteLock[i] = (decState > PartLcPhase[i]);
      end
    end
  end

endmodule

`default_nettype wire

//--- otpFuseArray.sv
/* Simulated fuse storage and the execute stage of the controller.
   Writes can only set bits and are refused on a locked partition. */
`timescale 1ns/100ps
`default_nettype none

module otpFuseArray
  import otpPartPkg::*;
#(
  parameter int NumPartWords = 8,
  localparam int WordW = $clog2(NumPartWords),
  localparam int NumWords = NumPart * NumPartWords
) (
  input  wire logic                 coreClk,
  input  wire logic                 rst,
  otpReqIf.execute                  req,
  input  wire logic [NumPart-1:0]   partWriteLock,
  output logic                      rspValid,
  output logic                      rspErr,
  output logic      [FuseWidth-1:0] rspData
);

  logic [FuseWidth-1:0] fuseMem [NumWords];

  // Flat word index, partition in the upper bits
  logic [$bits(partIdx)+WordW-1:0] idx;
  logic [FuseWidth-1:0]            curWord;
  logic [FuseWidth-1:0]            progWord;
  logic                            locked;
  logic                            doWrite;

  assign idx      = {req.part, req.word};
  assign curWord  = fuseMem[idx];
  // Programming blows extra fuses and never clears one
  assign progWord = curWord | req.wdata;
  assign locked   = partWriteLock[req.part];
  assign doWrite  = req.valid && req.write && !locked;

  // Array and status update on the edge that sees the request
  always_ff @(posedge coreClk) begin
    if (rst) begin
      // The model has no retention, so reset blanks every fuse
      for (int i = 0; i < NumWords; i++) begin
        fuseMem[i] <= '0;
      end
      rspValid <= 1'b0;
      rspErr   <= 1'b0;
    end else begin
      rspValid <= req.valid;
      if (req.valid) begin
        // Only a write into a locked partition fails, reads always pass
        rspErr <= req.write && locked;
      end
      if (doWrite) begin
        fuseMem[idx] <= progWord;
      end
    end
  end

  // Returned word is the content after the access
  always_ff @(posedge coreClk) begin
    if (req.valid) begin
      rspData <= doWrite ? progWord : curWord;
    end
  end

endmodule

`default_nettype wire

//--- otpResponse.sv
/* Wishbone response stage. Turns the fuse array outcome into a single
   ack or err pulse with read data, and tells decode the bus is free. */
`timescale 1ns/100ps
`default_nettype none

module otpResponse
  import otpPartPkg::*;
(
  input  wire logic                 coreClk,
  input  wire logic                 rst,
  input  wire logic                 rspValid,
  input  wire logic                 rspErr,
  input  wire logic [FuseWidth-1:0] rspData,
  output logic                      wbAck,
  output logic                      wbErr,
  output logic      [FuseWidth-1:0] wbDatR,
  output logic                      rspDone
);

  logic okRsp;

  assign okRsp = rspValid && !rspErr;

  // rspValid is a single-cycle pulse, so ack and err last one cycle
  always_ff @(posedge coreClk) begin
    if (rst) begin
      wbAck <= 1'b0;
      wbErr <= 1'b0;
    end else begin
      wbAck <= okRsp;
      wbErr <= rspValid && rspErr;
    end
  end

  // Data is loaded with each ack and held until the next one
  // A write ack also loads it and the master ignores DAT_R on writes
  always_ff @(posedge coreClk) begin
    if (okRsp) begin
      wbDatR <= rspData;
    end
  end

  // Lets decode release busy once the master has seen the response
  assign rspDone = wbAck || wbErr;

endmodule

`default_nettype wire

//--- otpFuseCtrl.sv
/* Top level of the OTP fuse controller with life-cycle write locking.
   Wishbone classic slave in, lock status out, fixed three-edge latency. */
`timescale 1ns/100ps
`default_nettype none

module otpFuseCtrl
  import lcStatePkg::*;
  import otpPartPkg::*;
#(
  parameter int NumPartWords = 8,
  localparam int AdrW = $bits(partIdx) + $clog2(NumPartWords)
) (
  input  wire logic                    coreClk,
  input  wire logic                    rst,
  // Wishbone classic slave
  input  wire logic                    wbCyc,
  input  wire logic                    wbStb,
  input  wire logic                    wbWe,
  input  wire logic [AdrW-1:0]         wbAdr,
  input  wire logic [FuseWidth-1:0]    wbDatW,
  output logic      [FuseWidth-1:0]    wbDatR,
  output logic                         wbAck,
  output logic                         wbErr,
  // Life-cycle state and the resulting lock of each partition
  input  wire logic [LcStateWidth-1:0] lcState,
  output logic      [NumPart-1:0]      partWriteLock
);

  logic                 rspValid;
  logic                 rspErr;
  logic [FuseWidth-1:0] rspData;
  logic                 rspDone;

  otpReqIf #(.NumPartWords(NumPartWords)) reqIf ();

  otpBusDecode #(.NumPartWords(NumPartWords)) u_otpBusDecode (
    .coreClk (coreClk),
    .rst     (rst),
    .wbCyc   (wbCyc),
    .wbStb   (wbStb),
    .wbWe    (wbWe),
    .wbAdr   (wbAdr),
    .wbDatW  (wbDatW),
    .rspDone (rspDone),
    .req     (reqIf.decode)
  );

  // Lock runs beside execute and is also visible at the top level
  lcPartitionLock u_lcPartitionLock (
    .coreClk       (coreClk),
    .rst           (rst),
    .lcState       (lcState),
    .partWriteLock (partWriteLock)
  );

  otpFuseArray #(.NumPartWords(NumPartWords)) u_otpFuseArray (
    .coreClk       (coreClk),
    .rst           (rst),
    .req           (reqIf.execute),
    .partWriteLock (partWriteLock),
    .rspValid      (rspValid),
    .rspErr        (rspErr),
    .rspData       (rspData)
  );

  otpResponse u_otpResponse (
    .coreClk  (coreClk),
    .rst      (rst),
    .rspValid (rspValid),
    .rspErr   (rspErr),
    .rspData  (rspData),
    .wbAck    (wbAck),
    .wbErr    (wbErr),
    .wbDatR   (wbDatR),
    .rspDone  (rspDone)
  );

endmodule

`default_nettype wire

//--- tbClockGen.sv
/* Free-running testbench clock with an 8 ns period.
   Starts low at time zero. */
`timescale 1ns/100ps
`default_nettype none

module tbClockGen (
  output logic coreClk
);

  initial begin
    coreClk = 1'b0;
  end

  // Half period of 4 ns
  always #4 coreClk = ~coreClk;

endmodule

`default_nettype wire

//--- otpFuseCtrlTb.sv
/* Testbench for the OTP fuse controller. Drives random Wishbone traffic and
   life-cycle codewords and checks every response against a local model. */
`timescale 1ns/100ps
`default_nettype none

module otpFuseCtrlTb;

  localparam int NumPartWords = 8;
  localparam int NumPart = 4;
  localparam int NumCodes = 12;
  // Decoded position of Scrap, one past the last codeword
  localparam int ScrapPhase = 12;
  // The sequence below needs a little under 2000 cycles
  localparam int TimeoutCycles = 4000;

  logic        coreClk;
  logic        rst;
  logic        wbCyc;
  logic        wbStb;
  logic        wbWe;
  logic [4:0]  wbAdr;
  logic [31:0] wbDatW;
  logic [31:0] wbDatR;
  logic        wbAck;
  logic        wbErr;
  logic [15:0] lcState;
  logic [3:0]  partWriteLock;

  int          cycleCnt = 0;
  // Edge on which the last ack or err was seen
  int          lastRspCycle;
  logic [3:0]  expLock;
  logic [31:0] modelMem [NumPart][NumPartWords];
  // Codewords in life-cycle order, so the index is the decoded phase
  logic [15:0] codeTable [NumCodes];
  // Last phase in which partitions 0 to 2 may be written
  int          lastPhase [NumPart];

  tbClockGen u_tbClockGen (.coreClk(coreClk));

  otpFuseCtrl #(.NumPartWords(NumPartWords)) u_otpFuseCtrl (
    .coreClk       (coreClk),
    .rst           (rst),
    .wbCyc         (wbCyc),
    .wbStb         (wbStb),
    .wbWe          (wbWe),
    .wbAdr         (wbAdr),
    .wbDatW        (wbDatW),
    .wbDatR        (wbDatR),
    .wbAck         (wbAck),
    .wbErr         (wbErr),
    .lcState       (lcState),
    .partWriteLock (partWriteLock)
  );

  task automatic stopWithFail(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "run stopped at %0t", $time);
  endtask

  task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
    if (actual !== expected) begin
      stopWithFail($sformatf("mismatch at %0t: %s, got %h, expected %h",
                             $time, what, actual, expected));
    end
  endtask

  // Run ends here if the sequence ever stalls
  always @(posedge coreClk) begin
    cycleCnt <= cycleCnt + 1;
    if (cycleCnt >= TimeoutCycles) begin
      stopWithFail("timeout: the run went past its cycle limit");
    end
  end

  function automatic int phaseOf(input logic [15:0] code);
    int phase;
    phase = ScrapPhase;
    for (int i = 0; i < NumCodes; i++) begin
      if (codeTable[i] == code) begin
        phase = i;
      end
    end
    return phase;
  endfunction

  function automatic logic [3:0] lockFor(input int phase);
    logic [3:0] lock;
    for (int p = 0; p < NumPart; p++) begin
      if (p == NumPart - 1) begin
        // The life-cycle partition only locks in Scrap
        lock[p] = (phase == ScrapPhase);
      end else begin
        lock[p] = (phase > lastPhase[p]);
      end
    end
    return lock;
  endfunction

  // One Wishbone classic cycle, always entered 1 ns after a rising edge
  task automatic busCycle(input logic we, input logic [1:0] part, input logic [2:0] word,
                          input logic [31:0] data, input logic holdStb,
                          output logic gotErr, output logic [31:0] rdata);
    int   acceptCycle;
    int   expectCycle;
    logic done;
    wbCyc  = 1'b1;
    wbStb  = 1'b1;
    wbWe   = we;
    wbAdr  = {part, word};
    wbDatW = data;
    // Decode is free again two edges after the previous response
    acceptCycle = cycleCnt + 1;
    if (lastRspCycle + 2 > acceptCycle) begin
      acceptCycle = lastRspCycle + 2;
    end
    expectCycle = acceptCycle + 2;
    done = 1'b0;
    while (!done) begin
      @(posedge coreClk);
      #1;
      if (wbAck && wbErr) begin
        stopWithFail("ack and err were high in the same cycle");
      end
      if (wbAck || wbErr) begin
        checkEq(cycleCnt, expectCycle, "response edge");
        done = 1'b1;
      end else if (cycleCnt >= expectCycle) begin
        stopWithFail("no ack or err arrived within the fixed latency");
      end
    end
    gotErr = wbErr;
    rdata = wbDatR;
    lastRspCycle = cycleCnt;
    if (!holdStb) begin
      wbCyc = 1'b0;
      wbStb = 1'b0;
      @(posedge coreClk);
      #1;
      if (wbAck || wbErr) begin
        stopWithFail("a second response followed a single request");
      end
    end
  endtask

  task automatic writeWord(input logic [1:0] part, input logic [2:0] word,
                           input logic [31:0] data, input logic holdStb);
    logic        gotErr;
    logic        expErr;
    logic [31:0] rdata;
    expErr = expLock[part];
    busCycle(1'b1, part, word, data, holdStb, gotErr, rdata);
    checkEq({31'd0, gotErr}, {31'd0, expErr}, $sformatf("write err p%0d w%0d", part, word));
    // Fuses can only be set, never cleared
    if (!expErr) begin
      modelMem[part][word] = modelMem[part][word] | data;
    end
  endtask

  task automatic readWord(input logic [1:0] part, input logic [2:0] word,
                          input logic holdStb);
    logic        gotErr;
    logic [31:0] rdata;
    busCycle(1'b0, part, word, 32'd0, holdStb, gotErr, rdata);
    checkEq({31'd0, gotErr}, 32'd0, $sformatf("read err p%0d w%0d", part, word));
    checkEq(rdata, modelMem[part][word], $sformatf("read data p%0d w%0d", part, word));
  endtask

  // New life-cycle word, then two quiet cycles for the lock to follow
  task automatic setLc(input logic [15:0] code);
    lcState = code;
    expLock = lockFor(phaseOf(code));
    repeat (2) begin
      @(posedge coreClk);
      #1;
      if (wbAck || wbErr) begin
        stopWithFail("response seen while the bus was idle");
      end
      // The lock already follows one edge after the new word
      checkEq({28'd0, partWriteLock}, {28'd0, expLock}, $sformatf("lock for code %h", code));
    end
  endtask

  initial begin
    logic [31:0] rnd;
    logic [15:0] code;
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe = 1'b0;
    wbAdr = '0;
    wbDatW = '0;
    lcState = 16'h0000;
    rst = 1'b1;
    lastRspCycle = -10;
    expLock = '0;
    codeTable = '{16'h0000, 16'h3A5C, 16'h71E2, 16'hB4C9, 16'hC61F, 16'h5E93,
                  16'h8D27, 16'hE3B6, 16'h2F4D, 16'h96E8, 16'h4BD1, 16'hF87A};
    lastPhase = '{7, 8, 9, ScrapPhase};
    for (int p = 0; p < NumPart; p++) begin
      for (int w = 0; w < NumPartWords; w++) begin
        modelMem[p][w] = '0;
      end
    end
    void'($urandom(32'h3980_0735));
    repeat (10) @(posedge coreClk);
    #1;
    rst = 1'b0;

    // Raw after reset leaves nothing locked and every fuse blank
    checkEq({28'd0, partWriteLock}, 32'd0, "lock after reset");
    for (int p = 0; p < NumPart; p++) begin
      for (int w = 0; w < NumPartWords; w++) begin
        readWord(2'(p), 3'(w), 1'b0);
      end
    end

    // Random traffic while all partitions are open
    // Sparse data keeps the OR from saturating too quickly
    setLc(codeTable[1]);
    for (int n = 0; n < 80; n++) begin
      rnd = $urandom;
      if (rnd[5]) begin
        writeWord(rnd[1:0], rnd[4:2], $urandom & $urandom, 1'b0);
      end else begin
        readWord(rnd[1:0], rnd[4:2], 1'b0);
      end
    end
    for (int p = 0; p < NumPart; p++) begin
      for (int w = 0; w < NumPartWords; w++) begin
        readWord(2'(p), 3'(w), 1'b0);
      end
    end

    // Walk every defined state, one write and read back per partition
    for (int i = 0; i < NumCodes; i++) begin
      setLc(codeTable[i]);
      for (int p = 0; p < NumPart; p++) begin
        rnd = $urandom;
        writeWord(2'(p), rnd[2:0], $urandom & $urandom, 1'b0);
        readWord(2'(p), rnd[2:0], 1'b0);
      end
    end

    // Unlisted codewords must decode as Scrap
    for (int n = 0; n < 12; n++) begin
      rnd = $urandom;
      code = rnd[15:0];
      while (phaseOf(code) != ScrapPhase) begin
        rnd = $urandom;
        code = rnd[15:0];
      end
      setLc(code);
      // Scrap locks every partition including the life-cycle one
      checkEq({28'd0, partWriteLock}, 32'h0000_000F, "lock in Scrap");
      for (int p = 0; p < NumPart; p++) begin
        rnd = $urandom;
        writeWord(2'(p), rnd[2:0], $urandom, 1'b0);
        readWord(2'(p), rnd[2:0], 1'b0);
      end
    end

    // Two bursts with stb held from one request to the next
    setLc(codeTable[1]);
    for (int b = 0; b < 2; b++) begin
      for (int k = 0; k < 24; k++) begin
        rnd = $urandom;
        if (rnd[5]) begin
          writeWord(rnd[1:0], rnd[4:2], $urandom & $urandom, k != 23);
        end else begin
          readWord(rnd[1:0], rnd[4:2], k != 23);
        end
      end
    end

    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
lcStatePkg.sv
otpPartPkg.sv
otpReqIf.sv
otpBusDecode.sv
lcPartitionLock.sv
otpFuseArray.sv
otpResponse.sv
otpFuseCtrl.sv
tbClockGen.sv
otpFuseCtrlTb.sv

//--- run.sh
#!/bin/sh
# Builds the fuse controller testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module otpFuseCtrlTb -o otpFuseCtrlSim
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
  echo "Verilator build failed with status $buildStatus"
  exit 1
fi

./obj_dir/otpFuseCtrlSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -q "=== PASS ===" sim.log; then
  echo "Test passed"
  exit 0
else
  echo "Pass message not found in sim.log"
  exit 1
fi
